/* uart_pkg.sv */
// UART shared types, parity modes and parity helper for transmitter and receiver

package uart_pkg;

    //////////////////////////////
    // Data types
    //////////////////////////////

    typedef logic [7:0] byte_t;     // One serial data byte

    typedef enum logic [1:0]
    {
        PARITY_NONE = 2'd0,
        PARITY_EVEN = 2'd1,
        PARITY_ODD  = 2'd2
    } parity_e;

    // Receive record as it sits in the receive FIFO
    typedef struct packed
    {
        byte_t data;
        logic  parity_err;          // Sampled parity bit disagrees with mode
        logic  frame_err;           // First stop bit sampled low
    } rx_frame_t;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Bit that goes on the line after the data bits
    function automatic logic parity_bit(byte_t data, parity_e mode);
        logic p;
        p = ^data;
        if (mode == PARITY_ODD)
        begin
            p = ~p;
        end
        return p;
    endfunction

endpackage

/* sync_fifo.sv */
// Synchronous FIFO with type-parameter payload, valid/ready ports and a room flag
`timescale 1ns/1ps

module sync_fifo #(
    parameter type T          = logic [7:0],
    parameter int  FIFO_DEPTH = 8,              // Power of two
    parameter int  ROOM_LEVEL = FIFO_DEPTH      // Fill level that clears has_room
) (
    input  logic clk,
    input  logic rst,
    input  T     wr_data,
    input  logic wr_valid,
    output logic wr_ready,
    output T     rd_data,
    output logic rd_valid,
    input  logic rd_ready,
    output logic has_room
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    T                 mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic             do_wr;
    logic             do_rd;

    assign wr_ready = (count != CNT_W'(FIFO_DEPTH));    // Back-pressure while full
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];
    assign do_wr    = wr_valid && wr_ready;
    assign do_rd    = rd_valid && rd_ready;

    always_comb
    begin
        count_next = count;
        if (do_wr && !do_rd)
        begin
            count_next = count + 1'b1;
        end
        else if (do_rd && !do_wr)
        begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_wr)
        begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            has_room <= 1'b1;
        end
        else
        begin
            if (do_wr)
            begin
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at depth
            end
            if (do_rd)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count    <= count_next;
            has_room <= (int'(count_next) < ROOM_LEVEL);
        end
    end

endmodule

/* uart_tx.sv */
// UART transmitter: serializes start, data, parity and stop bits with cts gating
`timescale 1ns/1ps

module uart_tx #(
    parameter int                CLKS_PER_BIT = 434,
    parameter uart_pkg::parity_e PARITY       = uart_pkg::PARITY_EVEN,
    parameter int                STOP_BITS    = 1,
    parameter bit                FLOW_CONTROL = 1'b1
) (
    input  logic            clk,
    input  logic            rst,
    input  uart_pkg::byte_t data,
    input  logic            valid,
    output logic            ready,
    input  logic            cts,
    output logic            tx
);

    localparam int STOP_CLKS = STOP_BITS * CLKS_PER_BIT;
    localparam int CNT_W     = $clog2(STOP_CLKS);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] STOP_LAST = CNT_W'(STOP_CLKS - 2); // Idle cycle ends stop

    typedef enum logic [2:0]
    {
        S_IDLE,
        S_START,
        S_DATA,
        S_PARITY,
        S_STOP
    } state_e;

    state_e           state;
    logic [CNT_W-1:0] clk_cnt;      // Clocks within the current bit
    logic [2:0]       bit_idx;
    uart_pkg::byte_t  data_q;
    logic             parity_q;
    logic             start_ok;

    assign start_ok = !FLOW_CONTROL || cts;
    assign ready    = (state == S_IDLE) && start_ok;

    // Byte and its parity are captured on the transfer
    always_ff @(posedge clk)
    begin
        if (valid && ready)
        begin
            data_q   <= data;
            parity_q <= uart_pkg::parity_bit(data, PARITY);
        end
    end

    //////////////////////////////
    // Frame FSM
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= S_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (valid && ready)
                    begin
                        tx    <= 1'b0;          // Start bit
                        state <= S_START;
                    end
                end
                S_START:
                begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (clk_cnt == BIT_LAST)
                    begin
                        clk_cnt <= '0;
                        tx      <= data_q[0];   // LSB first
                        state   <= S_DATA;
                    end
                end
                S_DATA:
                begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (clk_cnt == BIT_LAST)
                    begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx != 3'd7)
                        begin
                            tx <= data_q[bit_idx + 3'd1];
                        end
                        else if (PARITY != uart_pkg::PARITY_NONE)
                        begin
                            tx    <= parity_q;
                            state <= S_PARITY;
                        end
                        else
                        begin
                            tx    <= 1'b1;
                            state <= S_STOP;
                        end
                    end
                end
                S_PARITY:
                begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (clk_cnt == BIT_LAST)
                    begin
                        clk_cnt <= '0;
                        tx      <= 1'b1;
                        state   <= S_STOP;
                    end
                end
                S_STOP:
                begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (clk_cnt == STOP_LAST)
                    begin
                        state <= S_IDLE;        // May take next byte at once
                    end
                end
                default:
                begin
                    state <= S_IDLE;
                    tx    <= 1'b1;
                end
            endcase
        end
    end

endmodule

/* uart_rx.sv */
// UART receiver: detects start edges, samples mid-bit and checks parity and stop
`timescale 1ns/1ps

module uart_rx #(
    parameter int                CLKS_PER_BIT = 434,
    parameter uart_pkg::parity_e PARITY       = uart_pkg::PARITY_EVEN
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                rx,
    output uart_pkg::rx_frame_t frame,
    output logic                valid,
    input  logic                ready
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [2:0]
    {
        S_IDLE,
        S_START,
        S_DATA,
        S_PARITY,
        S_STOP,
        S_WAIT_HIGH
    } state_e;

    state_e           state;
    logic             rx_meta;
    logic             rx_sync;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    uart_pkg::byte_t  shift_q;
    logic             parity_err_q;
    logic             sample;       // Mid-bit point of data, parity and stop bits

    assign sample = (clk_cnt == BIT_LAST);

    // Line is asynchronous to clk
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    //////////////////////////////
    // Frame FSM
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state        <= S_WAIT_HIGH;
            clk_cnt      <= '0;
            bit_idx      <= '0;
            parity_err_q <= 1'b0;
            valid        <= 1'b0;
        end
        else
        begin
            if (valid && ready)
            begin
                valid <= 1'b0;                  // Record taken by the FIFO
            end
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                S_IDLE:
                begin
                    clk_cnt <= '0;
                    if (!rx_sync)
                    begin
                        state <= S_START;
                    end
                end
                S_START:
                begin
                    if (clk_cnt == HALF_LAST)
                    begin
                        clk_cnt      <= '0;
                        bit_idx      <= '0;
                        parity_err_q <= 1'b0;
                        // A high start bit is a glitch
                        state        <= rx_sync ? S_IDLE : S_DATA;
                    end
                end
                S_DATA:
                begin
                    if (sample)
                    begin
                        clk_cnt <= '0;
                        shift_q <= {rx_sync, shift_q[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                        begin
                            state <= (PARITY != uart_pkg::PARITY_NONE) ? S_PARITY : S_STOP;
                        end
                    end
                end
                S_PARITY:
                begin
                    if (sample)
                    begin
                        clk_cnt      <= '0;
                        parity_err_q <= (rx_sync != uart_pkg::parity_bit(shift_q, PARITY));
                        state        <= S_STOP;
                    end
                end
                S_STOP:
                begin
                    if (sample)
                    begin
                        clk_cnt          <= '0;
                        frame.data       <= shift_q;
                        frame.parity_err <= parity_err_q;
                        frame.frame_err  <= !rx_sync;   // Stop bit must be high
                        valid            <= 1'b1;
                        state            <= S_WAIT_HIGH;
                    end
                end
                S_WAIT_HIGH:
                begin
                    clk_cnt <= '0;
                    // Start edges stay ignored until the record is accepted
                    if (rx_sync && (!valid || ready))
                    begin
                        state <= S_IDLE;
                    end
                end
                default:
                begin
                    state <= S_WAIT_HIGH;
                end
            endcase
        end
    end

endmodule

/* uart_port.sv */
// UART port top: transmit FIFO and serializer, deserializer and receive FIFO
`timescale 1ns/1ps

module uart_port #(
    parameter int                CLKS_PER_BIT = 434,
    parameter uart_pkg::parity_e PARITY       = uart_pkg::PARITY_EVEN,
    parameter int                STOP_BITS    = 1,
    parameter int                FIFO_DEPTH   = 16,
    parameter int                ROOM_LEVEL   = 12,
    parameter bit                FLOW_CONTROL = 1'b1
) (
    input  logic                clk,
    input  logic                rst,
    // Serial line
    input  logic                rx,
    output logic                tx,
    input  logic                cts,    // Peer can take data
    output logic                rts,    // Receive FIFO has room
    // Host transmit port
    input  uart_pkg::byte_t     tx_data,
    input  logic                tx_valid,
    output logic                tx_ready,
    // Host receive port
    output uart_pkg::rx_frame_t rx_frame,
    output logic                rx_valid,
    input  logic                rx_ready
);

    uart_pkg::byte_t     txq_data;
    logic                txq_valid;
    logic                txq_ready;
    uart_pkg::rx_frame_t rxe_frame;
    logic                rxe_valid;
    logic                rxe_ready;

    //////////////////////////////
    // Transmit path
    //////////////////////////////

    sync_fifo #(
        .T          (uart_pkg::byte_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) tx_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (tx_data),
        .wr_valid (tx_valid),
        .wr_ready (tx_ready),
        .rd_data  (txq_data),
        .rd_valid (txq_valid),
        .rd_ready (txq_ready),
        .has_room ()
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .PARITY       (PARITY),
        .STOP_BITS    (STOP_BITS),
        .FLOW_CONTROL (FLOW_CONTROL)
    ) tx_engine (
        .clk   (clk),
        .rst   (rst),
        .data  (txq_data),
        .valid (txq_valid),
        .ready (txq_ready),
        .cts   (cts),
        .tx    (tx)
    );

    //////////////////////////////
    // Receive path
    //////////////////////////////

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .PARITY       (PARITY)
    ) rx_engine (
        .clk   (clk),
        .rst   (rst),
        .rx    (rx),
        .frame (rxe_frame),
        .valid (rxe_valid),
        .ready (rxe_ready)
    );

    sync_fifo #(
        .T          (uart_pkg::rx_frame_t),
        .FIFO_DEPTH (FIFO_DEPTH),
        .ROOM_LEVEL (ROOM_LEVEL)
    ) rx_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (rxe_frame),
        .wr_valid (rxe_valid),
        .wr_ready (rxe_ready),
        .rd_data  (rx_frame),
        .rd_valid (rx_valid),
        .rd_ready (rx_ready),
        .has_room (rts)        // Flow control toward the peer
    );

endmodule

/* tb_clock_gen.sv */
// Testbench clock and reset source with a 4 ns period and a 16 cycle reset
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;          // 4 ns period
    end

    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* tb_uart_port.sv */
// Testbench for the UART port: file driven host traffic, remote line model and checks
`timescale 1ns/1ps

module tb_uart_port;

    localparam int                CLKS_PER_BIT = 8;
    localparam uart_pkg::parity_e PARITY       = uart_pkg::PARITY_EVEN;
    localparam int                STOP_BITS    = 2;
    localparam int                FIFO_DEPTH   = 8;
    localparam int                ROOM_LEVEL   = 6;
    localparam bit                FLOW_CONTROL = 1'b1;
    localparam int                WAIT_LIMIT   = 4000;     // Cycles per bounded wait
    localparam int                IDLE_LIMIT   = 200000;   // Line monitor idle bound
    localparam logic [15:0]       LFSR_SEED    = 16'd12022;

    logic                clk;
    logic                rst;
    logic                rx;
    logic                tx;
    logic                cts;
    logic                rts;
    uart_pkg::byte_t     tx_data;
    logic                tx_valid;
    logic                tx_ready;
    uart_pkg::rx_frame_t rx_frame;
    logic                rx_valid;
    logic                rx_ready;

    uart_pkg::byte_t     exp_tx[$];     // Bytes the line monitor must see
    uart_pkg::rx_frame_t exp_rx[$];     // Records the host port must deliver
    logic [15:0]         lfsr;

    tb_clock_gen #(.RESET_CYCLES(16)) clock_gen (.clk(clk), .rst(rst));

    uart_port #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .PARITY       (PARITY),
        .STOP_BITS    (STOP_BITS),
        .FIFO_DEPTH   (FIFO_DEPTH),
        .ROOM_LEVEL   (ROOM_LEVEL),
        .FLOW_CONTROL (FLOW_CONTROL)
    ) uut (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .tx       (tx),
        .cts      (cts),
        .rts      (rts),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .rx_frame (rx_frame),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready)
    );

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic report_error(string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic report_timeout(string what);
        $display("Timed out while waiting for %s", what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic report_bad_data(string what);
        $display("Malformed %s line in the test data file", what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_byte(uart_pkg::byte_t got, uart_pkg::byte_t exp, string what);
        if (got !== exp)
        begin
            report_error($sformatf("%s: got %02h, expected %02h", what, got, exp));
        end
    endtask

    task automatic check_frame(uart_pkg::rx_frame_t got, uart_pkg::rx_frame_t exp);
        if (got !== exp)
        begin
            report_error($sformatf("rx record: got data %02h pe %0b fe %0b, expected %02h %0b %0b",
                got.data, got.parity_err, got.frame_err,
                exp.data, exp.parity_err, exp.frame_err));
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp)
        begin
            report_error($sformatf("%s: got %0b, expected %0b", what, got, exp));
        end
    endtask

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    //////////////////////////////
    // Host and line drivers
    //////////////////////////////

    task automatic send_byte(uart_pkg::byte_t b);
        int n;
        n = 0;
        tx_data  = b;
        tx_valid = 1'b1;
        while (!tx_ready)
        begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT)
            begin
                report_timeout("tx_ready");
            end
        end
        exp_tx.push_back(b);
        @(negedge clk);                 // Transfer took place on the rising edge
        tx_valid = 1'b0;
    endtask

    // One frame on rx, then one idle bit so the record settles in the FIFO
    task automatic inject_frame(uart_pkg::byte_t b, logic par_bad, logic stop_bad);
        logic bits [11];
        bits[0] = 1'b0;
        for (int i = 0; i < 8; i++)
        begin
            bits[i + 1] = b[i];
        end
        bits[9]  = uart_pkg::parity_bit(b, PARITY) ^ par_bad;
        bits[10] = ~stop_bad;
        for (int i = 0; i < 11; i++)
        begin
            rx = bits[i];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        rx = 1'b1;
        repeat (CLKS_PER_BIT) @(negedge clk);
        exp_rx.push_back('{data: b, parity_err: par_bad, frame_err: stop_bad});
        check_bit(rts, (exp_rx.size() < ROOM_LEVEL), "rts after frame");
    endtask

    // Host takes every pending record with random rx_ready
    task automatic drain_records();
        int n;
        n = 0;
        while (exp_rx.size() > 0)
        begin
            @(negedge clk);
            lfsr     = lfsr_next(lfsr);
            rx_ready = lfsr[0];
            if (rx_ready && rx_valid)
            begin
                check_frame(rx_frame, exp_rx.pop_front());
            end
            n++;
            if (n > WAIT_LIMIT)
            begin
                report_timeout("receive records");
            end
        end
        @(negedge clk);
        rx_ready = 1'b0;
        @(negedge clk);
        check_bit(rts, 1'b1, "rts after drain");
        check_bit(rx_valid, 1'b0, "rx_valid after drain");
    endtask

    task automatic wait_tx_done();
        int n;
        n = 0;
        while (exp_tx.size() > 0)
        begin
            @(negedge clk);
            n++;
            if (n > 4 * WAIT_LIMIT)
            begin
                report_timeout("transmit frames on tx");
            end
        end
    endtask

    //////////////////////////////
    // Remote end decoder on tx
    //////////////////////////////

    initial
    begin : line_monitor
        uart_pkg::byte_t got;
        logic            par;
        int              idle;
        idle = 0;
        @(negedge clk);
        while (rst)
        begin
            @(negedge clk);
            idle++;
            if (idle > WAIT_LIMIT)
            begin
                report_timeout("reset release in the tx monitor");
            end
        end
        forever
        begin
            idle = 0;
            while (tx)
            begin
                @(negedge clk);
                idle++;
                if (idle > IDLE_LIMIT)
                begin
                    report_timeout("a start bit on tx");
                end
            end
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            check_bit(tx, 1'b0, "tx start bit");
            for (int i = 0; i < 8; i++)
            begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                got[i] = tx;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            par = tx;
            for (int i = 0; i < STOP_BITS; i++)
            begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                check_bit(tx, 1'b1, "tx stop bit");
            end
            if (exp_tx.size() == 0)
            begin
                report_error($sformatf("unexpected frame %02h on tx", got));
            end
            check_byte(got, exp_tx[0], "tx data");
            check_bit(par, uart_pkg::parity_bit(exp_tx[0], PARITY), "tx parity bit");
            void'(exp_tx.pop_front());
        end
    end

    //////////////////////////////
    // Command stream
    //////////////////////////////

    initial
    begin : main
        int          fd;
        int          cnt;
        int          n;
        byte         cmd;
        logic [7:0]  val;
        logic        b0;
        logic        b1;
        string       line;
        rx       = 1'b1;
        cts      = 1'b1;
        tx_data  = '0;
        tx_valid = 1'b0;
        rx_ready = 1'b0;
        lfsr     = LFSR_SEED;
        n = 0;
        @(negedge clk);
        while (rst)
        begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT)
            begin
                report_timeout("reset release");
            end
        end
        @(negedge clk);
        check_bit(tx, 1'b1, "tx after reset");
        check_bit(rts, 1'b1, "rts after reset");
        check_bit(tx_ready, 1'b1, "tx_ready after reset");
        check_bit(rx_valid, 1'b0, "rx_valid after reset");

        fd = $fopen("uart_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the test data file uart_testdata.txt");
            $display("Finished with errors");
            $fatal(1);
        end
        while ($fscanf(fd, " %c", cmd) == 1)
        begin
            case (cmd)
                "#":
                begin
                    cnt = $fgets(line, fd);
                end
                "S":
                begin
                    cnt = $fscanf(fd, "%h", val);
                    if (cnt != 1)
                    begin
                        report_bad_data("S");
                    end
                    send_byte(val);
                    if (!cts)
                    begin
                        repeat (4 * CLKS_PER_BIT)
                        begin
                            @(negedge clk);
                            check_bit(tx, 1'b1, "tx held idle while cts low");
                        end
                    end
                end
                "L":
                begin
                    cnt = $fscanf(fd, "%h %b %b", val, b0, b1);
                    if (cnt != 3)
                    begin
                        report_bad_data("L");
                    end
                    inject_frame(val, b0, b1);
                    if (exp_rx.size() >= ROOM_LEVEL)
                    begin
                        drain_records();
                    end
                end
                "C":
                begin
                    cnt = $fscanf(fd, "%b", b0);
                    if (cnt != 1)
                    begin
                        report_bad_data("C");
                    end
                    if (!b0)
                    begin
                        wait_tx_done();     // Line is idle before cts drops
                    end
                    cts = b0;
                end
                default:
                begin
                    $display("Unknown command in the test data file");
                    $display("Finished with errors");
                    $fatal(1);
                end
            endcase
        end
        $fclose(fd);
        wait_tx_done();
        drain_records();
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* uart_testdata.txt */
# S <hex byte>            host sends byte on the transmit port
# L <hex byte> <pe> <fe>  frame on rx, pe corrupts parity, fe pulls stop low
# C <bit>                 cts level
# Plain transmit bytes
S 55
S A3
S 00
S FF
# Receive frames with mixed errors, the sixth drops rts
L 3C 0 0
L 81 1 0
L 7E 0 1
L 00 1 1
L C5 0 0
L 12 0 0
# cts gating
C 0
S 96
C 1
# Burst beyond the transmit FIFO depth
S 01
S 02
S 04
S 08
S 10
S 20
S 40
S 80
S 7F
S BE
S C3
S 3A
# Interleaved traffic
L 5A 0 0
S 69
L E7 1 0
L FF 0 0

/* all.f */
uart_pkg.sv
sync_fifo.sv
uart_tx.sv
uart_rx.sv
uart_port.sv
tb_clock_gen.sv
tb_uart_port.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it; exit status is the result
verilator --binary --timing -f all.f --top-module tb_uart_port -o sim_uart_port \
    && ./obj_dir/sim_uart_port \
    || exit 1
